//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fir_tb
FILELIST  = list.f

BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run into $(LOG) and check the log"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG) || ! grep -q "Simulation PASSED" $(LOG); then \
		echo "Test failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/fir_sva.sv
`timescale 1ns/1ps

// Concurrent checks on the FIR subsystem top level
// Output valid against reset, the enable and the input strobe
module fir_sva import fir_pkg::*; #(
    parameter int TAP_NUM = 8
) (
    input logic clk_i,
    input logic rstn_i,
    input logic in_valid_i,
    input logic out_valid_o,
    input logic enabled_o
);

    localparam int TOP_LATENCY = fir_latency(TAP_NUM) + 1;

    int unsigned on_run; // Consecutive edges that saw the enable high

    always_ff @(posedge clk_i) begin
        if (!rstn_i || !enabled_o) begin
            on_run <= 0;
        end else if (on_run < 1000) begin
            on_run <= on_run + 1;
        end
    end

    // The scaler sees a cleared enable one edge after it falls
    a_off_no_valid: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !enabled_o |=> !out_valid_o)
        else $error("out_valid_o high while the filter is disabled");

    a_latency_hit: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $past(in_valid_i && enabled_o, TOP_LATENCY) && on_run >= TOP_LATENCY |-> out_valid_o)
        else $error("accepted sample gave no output after the fixed latency");

    a_latency_src: assert property (@(posedge clk_i) disable iff (!rstn_i)
        out_valid_o |-> $past(in_valid_i && enabled_o, TOP_LATENCY))
        else $error("output valid without an accepted sample at the fixed latency");

    a_reset_low: assert property (@(posedge clk_i) !rstn_i |=> !out_valid_o)
        else $error("out_valid_o high during reset");

endmodule

bind fir_top fir_sva #(
    .TAP_NUM(TAP_NUM)
) fir_sva_i (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .in_valid_i (in_valid_i),
    .out_valid_o(out_valid_o),
    .enabled_o  (enabled_o)
);

//--- bench/fir_tb.sv
`timescale 1ns/1ps

// Testbench of the multichannel FIR subsystem
// Drives configuration writes and random samples into fir_top and compares
// every output with a convolution model that rounds, shifts and saturates
module fir_tb import fir_pkg::*; ();

    localparam int CH_NUM      = 2;
    localparam int DATA_WIDTH  = 16;
    localparam int COEF_WIDTH  = 18;
    localparam int TAP_NUM     = 8;
    localparam int TOP_LATENCY = fir_latency(TAP_NUM) + 1; // Filter plus scaler register
    localparam longint OUT_MAX = (longint'(1) <<< (DATA_WIDTH - 1)) - 1;
    localparam longint OUT_MIN = -(longint'(1) <<< (DATA_WIDTH - 1));
    localparam int SHIFT_SET [5] = '{0, 3, 14, 18, 22};

    typedef logic [CH_NUM-1:0][DATA_WIDTH-1:0] sample_t;

    logic                                     clk_i;
    logic                                     rstn_i;
    logic                                     cfg_we_i;
    logic [CFG_ADDR_WIDTH-1:0]                cfg_addr_i;
    logic [CFG_DATA_WIDTH-1:0]                cfg_wdata_i;
    logic                                     in_valid_i;
    logic signed [CH_NUM-1:0][DATA_WIDTH-1:0] in_data_i;
    logic                                     out_valid_o;
    logic signed [CH_NUM-1:0][DATA_WIDTH-1:0] out_data_o;
    logic                                     enabled_o;

    integer  seed;
    int      cyc;
    int      errors;
    int      failures;
    int      pushed;
    int      dropped;
    int      out_count;
    bit      model_en;
    int      model_shift;
    longint  model_coef [TAP_NUM];
    longint  hist [CH_NUM][TAP_NUM]; // Accepted samples since the last enable, newest first
    sample_t exp_q [$];
    int      due_q [$];

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    fir_top fir_top_i (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .cfg_we_i   (cfg_we_i),
        .cfg_addr_i (cfg_addr_i),
        .cfg_wdata_i(cfg_wdata_i),
        .in_valid_i (in_valid_i),
        .in_data_i  (in_data_i),
        .out_valid_o(out_valid_o),
        .out_data_o (out_data_o),
        .enabled_o  (enabled_o)
    );

    task automatic check_value(input string what, input longint got, input longint exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic longint round_and_clamp(input longint acc, input int sh);
        longint r;
        r = acc;
        if (sh > 0) begin
            r = r + (longint'(1) <<< (sh - 1)); // Half an output step
        end
        r = r >>> sh;
        if (r > OUT_MAX) begin
            r = OUT_MAX;
        end else if (r < OUT_MIN) begin
            r = OUT_MIN;
        end
        return r;
    endfunction

    function automatic sample_t rand_sample();
        sample_t s;
        for (int ch = 0; ch < CH_NUM; ch++) begin
            s[ch] = DATA_WIDTH'($random(seed));
        end
        return s;
    endfunction

    // Convolution of the history with the coefficients the model holds
    task automatic push_expected(input sample_t smp);
        sample_t want;
        longint  acc;
        for (int ch = 0; ch < CH_NUM; ch++) begin
            for (int k = TAP_NUM - 1; k > 0; k--) begin
                hist[ch][k] = hist[ch][k-1];
            end
            hist[ch][0] = longint'($signed(smp[ch]));
            acc = 0;
            for (int k = 0; k < TAP_NUM; k++) begin
                acc = acc + model_coef[k] * hist[ch][k];
            end
            want[ch] = DATA_WIDTH'(round_and_clamp(acc, model_shift));
        end
        exp_q.push_back(want);
        due_q.push_back(cyc + TOP_LATENCY + 1); // Taken on the next edge, seen at a negedge
        pushed++;
    endtask

    // Outputs that would leave after the enable falls never appear
    task automatic drop_in_flight(input int limit);
        while (due_q.size() != 0 && due_q[$] > limit) begin
            void'(due_q.pop_back());
            void'(exp_q.pop_back());
            dropped++;
        end
    endtask

    task automatic clear_history();
        for (int ch = 0; ch < CH_NUM; ch++) begin
            for (int k = 0; k < TAP_NUM; k++) begin
                hist[ch][k] = 0;
            end
        end
    endtask

    task automatic drive_cycle(input bit valid, input sample_t smp);
        @(posedge clk_i);
        in_valid_i <= valid;
        in_data_i  <= smp;
        if (valid && model_en) begin
            push_expected(smp);
        end
    endtask

    task automatic write_reg(input int addr, input logic [CFG_DATA_WIDTH-1:0] data);
        @(posedge clk_i);
        cfg_we_i    <= 1'b1;
        cfg_addr_i  <= CFG_ADDR_WIDTH'(addr);
        cfg_wdata_i <= data;
        in_valid_i  <= 1'b0;
        if (addr == int'(REG_CTRL)) begin
            if (data[0] && !model_en) begin
                clear_history();
            end
            if (!data[0] && model_en) begin
                drop_in_flight(cyc + 2); // Write lands on the next edge
            end
            model_en = data[0];
        end else if (addr == int'(REG_SHIFT)) begin
            model_shift = int'(data[SHIFT_WIDTH-1:0]);
        end else if (!model_en && addr >= int'(REG_COEF_BASE) &&
                     addr < int'(REG_COEF_BASE) + TAP_NUM) begin
            model_coef[addr - int'(REG_COEF_BASE)] = longint'($signed(data[COEF_WIDTH-1:0]));
        end
        @(posedge clk_i);
        cfg_we_i <= 1'b0;
        if (addr == int'(REG_CTRL)) begin
            @(negedge clk_i);
            check_value("enabled_o", longint'(enabled_o), longint'(data[0]));
        end
    endtask

    task automatic load_random_coefs();
        for (int k = 0; k < TAP_NUM; k++) begin
            write_reg(int'(REG_COEF_BASE) + k, $random(seed));
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            in_valid_i <= 1'b0;
        end
    endtask

    task automatic wait_drain(input int max_cycles);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < max_cycles) begin
            @(posedge clk_i);
            in_valid_i <= 1'b0;
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout after %0d cycles, %0d outputs never appeared", n, exp_q.size());
            failures++;
            exp_q.delete();
            due_q.delete();
        end
    endtask

    // Outputs are sampled mid-cycle, away from the driving edge
    always @(negedge clk_i) begin : monitor
        sample_t want;
        cyc = cyc + 1;
        if (out_valid_o === 1'b1) begin
            out_count++;
            if (exp_q.size() == 0) begin
                $display("Output at %0t ns appeared with no sample in flight", $time);
                failures++;
            end else begin
                want = exp_q.pop_front();
                check_value("output cycle", longint'(cyc), longint'(due_q.pop_front()));
                for (int ch = 0; ch < CH_NUM; ch++) begin
                    check_value($sformatf("channel %0d data", ch),
                                longint'($signed(out_data_o[ch])), longint'($signed(want[ch])));
                end
            end
        end
    end

    initial begin : stimulus
        sample_t impulse;
        seed = 32'h37bf_27a3;
        cyc = 0;
        errors = 0;
        failures = 0;
        pushed = 0;
        dropped = 0;
        out_count = 0;
        model_en = 1'b0;
        model_shift = 0;
        for (int k = 0; k < TAP_NUM; k++) begin
            model_coef[k] = 0;
        end
        clear_history();
        rstn_i      = 1'b0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = '0;
        cfg_wdata_i = '0;
        in_valid_i  = 1'b0;
        in_data_i   = '0;
        repeat (10) @(posedge clk_i);
        rstn_i <= 1'b1;

        // Idle after reset, strobes must be ignored
        for (int i = 0; i < 20; i++) begin
            drive_cycle(i[0], rand_sample());
            @(negedge clk_i);
            check_value("enabled_o while idle", longint'(enabled_o), 0);
        end

        // Impulse response
        for (int ch = 0; ch < CH_NUM; ch++) begin
            impulse[ch] = DATA_WIDTH'(1);
        end
        load_random_coefs();
        write_reg(int'(REG_SHIFT), 0);
        write_reg(int'(REG_CTRL), 1);
        drive_cycle(1'b1, impulse);
        repeat (TAP_NUM + 2) drive_cycle(1'b1, '0);
        wait_drain(4 * TOP_LATENCY);
        write_reg(int'(REG_CTRL), 0);

        // Random data with gaps under several shifts
        for (int r = 0; r < 5; r++) begin
            load_random_coefs();
            write_reg(int'(REG_SHIFT), SHIFT_SET[r]);
            write_reg(int'(REG_CTRL), 1);
            for (int i = 0; i < 60; i++) begin
                drive_cycle(($random(seed) & 3) != 0, rand_sample());
            end
            wait_drain(4 * TOP_LATENCY);
            write_reg(int'(REG_CTRL), 0);
        end

        // Coefficient write while running has no effect
        load_random_coefs();
        write_reg(int'(REG_SHIFT), 18);
        write_reg(int'(REG_CTRL), 1);
        write_reg(int'(REG_COEF_BASE) + 2, 32'h0001_ffff);
        repeat (30) drive_cycle(1'b1, rand_sample());
        wait_drain(4 * TOP_LATENCY);

        // Disable with samples in flight, then restart from zero history
        repeat (12) drive_cycle(1'b1, rand_sample());
        write_reg(int'(REG_CTRL), 0);
        idle_cycles(2 * TOP_LATENCY);
        check_value("outputs left after disable", longint'(exp_q.size()), 0);
        write_reg(int'(REG_CTRL), 1);
        repeat (20) drive_cycle(1'b1, rand_sample());
        wait_drain(4 * TOP_LATENCY);
        write_reg(int'(REG_CTRL), 0);

        // Back to back stream, the monitor checks the cycle of every output
        write_reg(int'(REG_SHIFT), 16);
        write_reg(int'(REG_CTRL), 1);
        repeat (40) drive_cycle(1'b1, rand_sample());
        wait_drain(4 * TOP_LATENCY);
        write_reg(int'(REG_CTRL), 0);
        idle_cycles(4);

        check_value("output count", longint'(out_count), longint'(pushed - dropped));
        $display("Done: %0d mismatches, %0d other failures, %0d outputs, %0d dropped",
                 errors, failures, out_count, dropped);
        if (errors == 0 && failures == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- hdl/fir_coef_regs.sv
`timescale 1ns/1ps

// Configuration register block of the FIR subsystem
// Holds the enable bit, the output shift and the coefficient bank
// Coefficient writes are dropped while the filter runs so that every sample
// in flight sees one coefficient set
module fir_coef_regs import fir_pkg::*; #(
    parameter int COEF_WIDTH = 18,
    parameter int TAP_NUM    = 8
) (
    input  logic clk_i,
    input  logic rstn_i,

    input  logic                      cfg_we_i,
    input  logic [CFG_ADDR_WIDTH-1:0] cfg_addr_i,
    input  logic [CFG_DATA_WIDTH-1:0] cfg_wdata_i,

    output logic                                      en_o,
    output logic [SHIFT_WIDTH-1:0]                    shift_o,
    output logic signed [TAP_NUM-1:0][COEF_WIDTH-1:0] coef_o
);

    logic coef_we;

    assign coef_we = cfg_we_i && !en_o; // Bank is frozen while enabled

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            en_o    <= 1'b0;
            shift_o <= '0;
        end else if (cfg_we_i) begin
            case (cfg_reg_e'(cfg_addr_i))
                REG_CTRL: begin
                    en_o <= cfg_wdata_i[0];
                end
                REG_SHIFT: begin
                    shift_o <= cfg_wdata_i[SHIFT_WIDTH-1:0];
                end
                default: begin
                    // Coefficients and unmapped addresses are handled below
                end
            endcase
        end
    end

    // One comparator per tap, so addresses outside the bank hit nothing
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            coef_o <= '0;
        end else if (coef_we) begin
            for (int k = 0; k < TAP_NUM; k++) begin
                if (cfg_addr_i == CFG_ADDR_WIDTH'(int'(REG_COEF_BASE) + k)) begin
                    coef_o[k] <= cfg_wdata_i[COEF_WIDTH-1:0]; // Low bits only
                end
            end
        end
    end

endmodule

//--- hdl/fir_filter.sv
`timescale 1ns/1ps

// Multichannel direct-form FIR filter with one shared coefficient set
// Each channel has one multiplier per tap and a registered binary adder tree
// whose unused leaves are tied to zero when TAP_NUM is not a power of two
// The tap delay line moves on accepted samples only and restarts from
// zero history each time the enable rises
module fir_filter import fir_pkg::*; #(
    parameter  int CH_NUM     = 2,
    parameter  int DATA_WIDTH = 16,
    parameter  int COEF_WIDTH = 18,
    parameter  int TAP_NUM    = 8,
    localparam int ACC_WIDTH  = fir_acc_width(DATA_WIDTH, COEF_WIDTH, TAP_NUM)
) (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic en_i,

    input  logic                                      tvalid_i,
    input  logic signed [CH_NUM-1:0][DATA_WIDTH-1:0]  tdata_i,
    input  logic signed [TAP_NUM-1:0][COEF_WIDTH-1:0] coef_i,

    output logic                                    tvalid_o,
    output logic signed [CH_NUM-1:0][ACC_WIDTH-1:0] tdata_o
);

    localparam int LATENCY = fir_latency(TAP_NUM);
    localparam int LEVELS  = $clog2(TAP_NUM);
    localparam int PAD_NUM = 1 << LEVELS; // Leaves of the adder tree

    logic en_q;
    logic en_rise;
    logic take;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            en_q <= 1'b0;
        end else begin
            en_q <= en_i;
        end
    end

    assign en_rise = en_i && !en_q;     // First enabled cycle
    assign take    = en_i && tvalid_i;  // Sample enters the delay line

    // Strobe runs alongside the data and is flushed while disabled
    shift_reg #(
        .DATA_WIDTH(1),
        .DELAY     (LATENCY),
        .RESET_EN  (1'b1)
    ) i_valid_dly (
        .clk_i (clk_i),
        .rstn_i(rstn_i),
        .en_i  (en_i),
        .data_i(tvalid_i),
        .data_o(tvalid_o)
    );

    for (genvar ch = 0; ch < CH_NUM; ch++) begin : g_ch
        logic signed [DATA_WIDTH-1:0] delay [TAP_NUM];
        logic signed [ACC_WIDTH-1:0]  mult  [PAD_NUM];
        logic signed [ACC_WIDTH-1:0]  tree  [2*PAD_NUM-1]; // Heap order, root at 0

        // A sample arriving together with the enable edge lands on a cleared line
        always_ff @(posedge clk_i) begin
            if (en_rise || take) begin
                delay[0] <= take ? $signed(tdata_i[ch]) : '0;
                for (int k = 1; k < TAP_NUM; k++) begin
                    delay[k] <= en_rise ? '0 : delay[k-1];
                end
            end
        end

        for (genvar k = 0; k < PAD_NUM; k++) begin : g_tap
            if (k < TAP_NUM) begin : g_mul
                assign mult[k] = ACC_WIDTH'(delay[k]) * ACC_WIDTH'($signed(coef_i[k]));
            end else begin : g_pad
                assign mult[k] = '0;
            end
        end

        // Leaves take the products, each inner node adds its two children
        always_ff @(posedge clk_i) begin
            for (int i = 0; i < PAD_NUM; i++) begin
                tree[PAD_NUM-1+i] <= mult[i];
            end
            for (int n = 0; n < PAD_NUM - 1; n++) begin
                tree[n] <= tree[2*n+1] + tree[2*n+2];
            end
            tdata_o[ch] <= tree[0];
        end
    end

endmodule

//--- hdl/fir_output_scaler.sv
`timescale 1ns/1ps

// Output scaler of the FIR subsystem
// Rounds half up, shifts right arithmetically and saturates every channel
// to the signed output width in one registered stage
module fir_output_scaler import fir_pkg::*; #(
    parameter int CH_NUM     = 2,
    parameter int DATA_WIDTH = 16,
    parameter int ACC_WIDTH  = 37
) (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic en_i,

    input  logic                                    valid_i,
    input  logic signed [CH_NUM-1:0][ACC_WIDTH-1:0] data_i,
    input  logic [SHIFT_WIDTH-1:0]                  shift_i,

    output logic                                     valid_o,
    output logic signed [CH_NUM-1:0][DATA_WIDTH-1:0] data_o
);

    localparam int EXT_WIDTH = ACC_WIDTH + 1; // Room for the rounding carry

    localparam logic signed [EXT_WIDTH-1:0] OUT_MAX =
        {{(EXT_WIDTH-DATA_WIDTH+1){1'b0}}, {(DATA_WIDTH-1){1'b1}}};
    localparam logic signed [EXT_WIDTH-1:0] OUT_MIN =
        {{(EXT_WIDTH-DATA_WIDTH+1){1'b1}}, {(DATA_WIDTH-1){1'b0}}};

    logic signed [EXT_WIDTH-1:0]  rnd_const;
    logic signed [EXT_WIDTH-1:0]  rounded [CH_NUM];
    logic signed [EXT_WIDTH-1:0]  shifted [CH_NUM];
    logic signed [DATA_WIDTH-1:0] clamped [CH_NUM];

    always_comb begin
        rnd_const = (shift_i == '0) ? '0 : EXT_WIDTH'(1) << (shift_i - 1'b1);
        for (int ch = 0; ch < CH_NUM; ch++) begin
            rounded[ch] = EXT_WIDTH'($signed(data_i[ch])) + rnd_const;
            // Shifts at or beyond the accumulator width always round to zero
            if (int'(shift_i) >= ACC_WIDTH) begin
                shifted[ch] = '0;
            end else begin
                shifted[ch] = rounded[ch] >>> shift_i;
            end
            if (shifted[ch] > OUT_MAX) begin
                clamped[ch] = OUT_MAX[DATA_WIDTH-1:0];
            end else if (shifted[ch] < OUT_MIN) begin
                clamped[ch] = OUT_MIN[DATA_WIDTH-1:0];
            end else begin
                clamped[ch] = shifted[ch][DATA_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= en_i && valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int ch = 0; ch < CH_NUM; ch++) begin
            data_o[ch] <= clamped[ch];
        end
    end

endmodule

//--- hdl/fir_pkg.sv
// Shared definitions of the multichannel FIR subsystem
// Holds the configuration bus widths, the register map and the helpers
// that derive the accumulator width and the filter latency from the parameters
package fir_pkg;

    // Configuration write bus
    localparam int CFG_ADDR_WIDTH = 8;
    localparam int CFG_DATA_WIDTH = 32;

    localparam int SHIFT_WIDTH = 6; // Output right shift field

    typedef enum logic [CFG_ADDR_WIDTH-1:0] {
        REG_CTRL      = CFG_ADDR_WIDTH'(0),  // Bit 0 enables the filter
        REG_SHIFT     = CFG_ADDR_WIDTH'(1),  // Arithmetic right shift of the output
        REG_COEF_BASE = CFG_ADDR_WIDTH'(16)  // Coefficient k lives at this address plus k
    } cfg_reg_e;

    // Sum of TAP_NUM full precision products without overflow
    function automatic int fir_acc_width(
        input int data_width,
        input int coef_width,
        input int tap_num
    );
        return data_width + coef_width + $clog2(tap_num);
    endfunction

    // Capture, multiply, one register per adder tree level, output register
    function automatic int fir_latency(
        input int tap_num
    );
        return 3 + $clog2(tap_num);
    endfunction

endpackage

//--- hdl/fir_top.sv
`timescale 1ns/1ps

// Top level of the multichannel FIR subsystem
// Register block, pipelined filter and output scaler in a chain
module fir_top import fir_pkg::*; #(
    parameter int CH_NUM     = 2,
    parameter int DATA_WIDTH = 16,
    parameter int COEF_WIDTH = 18,
    parameter int TAP_NUM    = 8
) (
    input  logic clk_i,
    input  logic rstn_i,

    input  logic                      cfg_we_i,
    input  logic [CFG_ADDR_WIDTH-1:0] cfg_addr_i,
    input  logic [CFG_DATA_WIDTH-1:0] cfg_wdata_i,

    input  logic                                     in_valid_i,
    input  logic signed [CH_NUM-1:0][DATA_WIDTH-1:0] in_data_i,

    output logic                                     out_valid_o,
    output logic signed [CH_NUM-1:0][DATA_WIDTH-1:0] out_data_o,
    output logic                                     enabled_o
);

    localparam int ACC_WIDTH = fir_acc_width(DATA_WIDTH, COEF_WIDTH, TAP_NUM);

    logic                                      en;
    logic [SHIFT_WIDTH-1:0]                    shift;
    logic signed [TAP_NUM-1:0][COEF_WIDTH-1:0] coef;
    logic                                      acc_valid;
    logic signed [CH_NUM-1:0][ACC_WIDTH-1:0]   acc_data;

    fir_coef_regs #(
        .COEF_WIDTH(COEF_WIDTH),
        .TAP_NUM   (TAP_NUM)
    ) i_coef_regs (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .cfg_we_i   (cfg_we_i),
        .cfg_addr_i (cfg_addr_i),
        .cfg_wdata_i(cfg_wdata_i),
        .en_o       (en),
        .shift_o    (shift),
        .coef_o     (coef)
    );

    fir_filter #(
        .CH_NUM    (CH_NUM),
        .DATA_WIDTH(DATA_WIDTH),
        .COEF_WIDTH(COEF_WIDTH),
        .TAP_NUM   (TAP_NUM)
    ) i_filter (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .en_i    (en),
        .tvalid_i(in_valid_i),
        .tdata_i (in_data_i),
        .coef_i  (coef),
        .tvalid_o(acc_valid),
        .tdata_o (acc_data)
    );

    fir_output_scaler #(
        .CH_NUM    (CH_NUM),
        .DATA_WIDTH(DATA_WIDTH),
        .ACC_WIDTH (ACC_WIDTH)
    ) i_scaler (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .en_i   (en),
        .valid_i(acc_valid),
        .data_i (acc_data),
        .shift_i(shift),
        .valid_o(out_valid_o),
        .data_o (out_data_o)
    );

    assign enabled_o = en;

endmodule

//--- hdl/shift_reg.sv
`timescale 1ns/1ps

// Register chain of configurable length and width
// Advances while enabled, optionally cleared on reset and while disabled
module shift_reg #(
    parameter int DATA_WIDTH = 1,
    parameter int DELAY      = 1,
    parameter bit RESET_EN   = 1'b0
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  en_i,
    input  logic [DATA_WIDTH-1:0] data_i,
    output logic [DATA_WIDTH-1:0] data_o
);

    logic [DATA_WIDTH-1:0] stage [DELAY];

    always_ff @(posedge clk_i) begin
        if (RESET_EN && (!rstn_i || !en_i)) begin
            for (int i = 0; i < DELAY; i++) begin
                stage[i] <= '0;
            end
        end else if (en_i) begin
            stage[0] <= data_i;
            for (int i = 1; i < DELAY; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign data_o = stage[DELAY-1]; // Oldest entry leaves the chain

endmodule

//--- list.f
hdl/fir_pkg.sv
hdl/shift_reg.sv
hdl/fir_coef_regs.sv
hdl/fir_filter.sv
hdl/fir_output_scaler.sv
hdl/fir_top.sv
bench/fir_sva.sv
bench/fir_tb.sv
